// File: design/eeprom_bus_pkg.sv
package eeprom_bus_pkg;

    // Fixed device type code of the 24C16 family
    localparam logic [3:0] dev_code = 4'b1010;

    // 2048 bytes: block bits 10:8 travel in the control byte
    localparam int addr_w = 11;
    localparam int data_w = 8;

    // One bus operation of the bit engine, each four sck quarters long
    typedef enum logic [1:0] {
        op_start,
        op_stop,
        op_write,
        op_read
    } bit_op_t;

endpackage

// File: design/eeprom_cmd_pkg.sv
package eeprom_cmd_pkg;

    // User request, data is a don't care for reads
    typedef struct packed {
        logic                              is_read;
        logic [eeprom_bus_pkg::addr_w-1:0] addr;
        logic [eeprom_bus_pkg::data_w-1:0] data;
    } eeprom_cmd_t;

    // Completion, data holds the read byte or zero after a write
    typedef struct packed {
        logic                              was_read;
        logic [eeprom_bus_pkg::data_w-1:0] data;
    } eeprom_rsp_t;

endpackage

// File: design/eeprom_bit_engine.sv
`timescale 1ns/1ps

module eeprom_bit_engine #(
    parameter int QUARTER_DIV = 4
) (
    input  logic                    scl,
    input  logic                    rst_n,
    input  logic                    bit_go,
    input  eeprom_bus_pkg::bit_op_t bit_op,
    input  logic                    bit_wr,
    input  logic                    sda_in,
    output logic                    bit_done,
    output logic                    bit_rd,
    output logic                    sck,
    output logic                    eng_sda_low
);
    import eeprom_bus_pkg::*;

    localparam int qcnt_w = (QUARTER_DIV > 1) ? $clog2(QUARTER_DIV) : 1;

    logic              active;
    logic [qcnt_w-1:0] qcnt;
    logic [1:0]        phase;
    logic              quarter_end;
    bit_op_t           op_q;
    logic              wr_q;

    // Returns {sck, sda_low} for one quarter of an operation
    function automatic logic [1:0] shape(input bit_op_t op, input logic wr, input logic [1:0] ph);
        logic       sck_hi;
        logic [1:0] s;
        sck_hi = (ph == 2'd1) || (ph == 2'd2);
        case (op)
            op_start:
            begin
                // Release sda with sck low, raise sck, then pull sda low
                case (ph)
                    2'd0:    s = 2'b00;
                    2'd1:    s = 2'b10;
                    2'd2:    s = 2'b11;
                    default: s = 2'b01;
                endcase
            end
            op_stop:
            begin
                // sda rises while sck stays high, bus left idle
                case (ph)
                    2'd0:    s = 2'b01;
                    2'd1:    s = 2'b11;
                    default: s = 2'b10;
                endcase
            end
            op_write: s = {sck_hi, ~wr};
            default:  s = {sck_hi, 1'b0};
        endcase
        return s;
    endfunction

    assign quarter_end = active && (qcnt == qcnt_w'(QUARTER_DIV - 1));
    assign bit_done    = quarter_end && (phase == 2'd3);

    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            active      <= 1'b0;
            qcnt        <= '0;
            phase       <= 2'd0;
            sck         <= 1'b1;
            eng_sda_low <= 1'b0;
        end
        else if (!active)
        begin
            if (bit_go)
            begin
                active                <= 1'b1;
                qcnt                  <= '0;
                phase                 <= 2'd0;
                {sck, eng_sda_low}    <= shape(bit_op, bit_wr, 2'd0);
            end
        end
        else if (quarter_end)
        begin
            qcnt  <= '0;
            phase <= phase + 2'd1;
            if (phase == 2'd3)
                active <= 1'b0;
            else
                {sck, eng_sda_low} <= shape(op_q, wr_q, phase + 2'd1);
        end
        else
        begin
            qcnt <= qcnt + 1'b1;
        end
    end

    always_ff @(posedge scl)
    begin
        if (!active && bit_go)
        begin
            op_q <= bit_op;
            wr_q <= bit_wr;
        end
        // Sample at the sck high midpoint
        if (quarter_end && (phase == 2'd1))
            bit_rd <= sda_in;
    end

endmodule

// File: design/eeprom_master.sv
`timescale 1ns/1ps

module eeprom_master (
    input  logic                        scl,
    input  logic                        rst_n,
    input  logic                        cmd_valid,
    input  eeprom_cmd_pkg::eeprom_cmd_t cmd,
    output logic                        busy,
    output logic                        rsp_valid,
    output eeprom_cmd_pkg::eeprom_rsp_t rsp,
    output logic                        bit_go,
    output eeprom_bus_pkg::bit_op_t     bit_op,
    output logic                        bit_wr,
    input  logic                        bit_done,
    input  logic                        bit_rd
);
    import eeprom_bus_pkg::*;
    import eeprom_cmd_pkg::*;

    typedef enum logic [3:0] {
        ph_idle,
        ph_start,
        ph_ctrl,
        ph_addr,
        ph_data,
        ph_restart,
        ph_rctrl,
        ph_rdata,
        ph_stop
    } phase_t;

    phase_t            phase;
    phase_t            next_byte_phase;
    logic [3:0]        bit_cnt;
    logic              ack_slot;
    eeprom_cmd_t       cmd_q;
    logic [7:0]        ctrl_byte;
    logic [data_w-1:0] tx_byte;
    logic [data_w-1:0] rd_shift;

    assign busy     = (phase != ph_idle);
    assign ack_slot = (bit_cnt == 4'd8);

    // Direction bit set only for the control byte after the repeated start
    assign ctrl_byte = {dev_code, cmd_q.addr[addr_w-1:data_w], phase == ph_rctrl};

    always_comb
    begin
        case (phase)
            ph_ctrl,
            ph_rctrl: tx_byte = ctrl_byte;
            ph_addr:  tx_byte = cmd_q.addr[data_w-1:0];
            ph_data:  tx_byte = cmd_q.data;
            default:  tx_byte = '1;
        endcase
    end

    always_comb
    begin
        case (phase)
            ph_ctrl:  next_byte_phase = ph_addr;
            ph_addr:  next_byte_phase = cmd_q.is_read ? ph_restart : ph_data;
            ph_rctrl: next_byte_phase = ph_rdata;
            default:  next_byte_phase = ph_stop;
        endcase
    end

    always_comb
    begin
        bit_wr = 1'b1;
        case (phase)
            ph_start,
            ph_restart: bit_op = op_start;
            ph_rdata:
            begin
                // NACK after the single read byte
                bit_op = ack_slot ? op_write : op_read;
            end
            ph_ctrl,
            ph_addr,
            ph_data,
            ph_rctrl:
            begin
                bit_op = ack_slot ? op_read : op_write;
                bit_wr = ack_slot | tx_byte[3'd7 - bit_cnt[2:0]];
            end
            default:    bit_op = op_stop;
        endcase
    end

    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            phase     <= ph_idle;
            bit_cnt   <= 4'd0;
            bit_go    <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            bit_go    <= 1'b0;
            rsp_valid <= 1'b0;
            if (phase == ph_idle)
            begin
                if (cmd_valid)
                begin
                    phase  <= ph_start;
                    bit_go <= 1'b1;
                end
            end
            else if (bit_done)
            begin
                case (phase)
                    ph_start,
                    ph_restart:
                    begin
                        phase   <= (phase == ph_start) ? ph_ctrl : ph_rctrl;
                        bit_cnt <= 4'd0;
                        bit_go  <= 1'b1;
                    end
                    ph_stop:
                    begin
                        phase     <= ph_idle;
                        rsp_valid <= 1'b1;
                    end
                    default:
                    begin
                        if (ack_slot)
                        begin
                            phase   <= next_byte_phase;
                            bit_cnt <= 4'd0;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                        bit_go <= 1'b1;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if ((phase == ph_idle) && cmd_valid)
            cmd_q <= cmd;
        if ((phase == ph_rdata) && bit_done && !ack_slot)
            rd_shift <= {rd_shift[data_w-2:0], bit_rd};
        if ((phase == ph_stop) && bit_done)
        begin
            rsp.was_read <= cmd_q.is_read;
            rsp.data     <= cmd_q.is_read ? rd_shift : '0;
        end
    end

endmodule

// File: design/eeprom_slave.sv
`timescale 1ns/1ps

module eeprom_slave (
    input  logic scl,
    input  logic rst_n,
    input  logic sck,
    input  logic sda,
    output logic slv_sda_low
);
    import eeprom_bus_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_ctrl,
        st_addr,
        st_data,
        st_read
    } slv_state_t;

    logic [2:0]        sck_sync;
    logic [2:0]        sda_sync;
    logic              sck_rise;
    logic              sck_fall;
    logic              start_det;
    logic              stop_det;
    slv_state_t        state;
    logic [3:0]        bit_cnt;
    logic              acking;
    logic              byte_done;
    logic              ctrl_ok;
    logic              mem_we;
    logic              rd_load;
    logic              rd_next;
    logic [data_w-1:0] shift;
    logic [data_w-1:0] addr_byte;
    logic [2:0]        block;
    logic [data_w-1:0] rd_byte;
    logic [data_w-1:0] mem [0:(1 << addr_w) - 1];

    // Bits 1 and 2 of each synchronizer are the current and previous samples
    assign sck_rise  = sck_sync[1] & ~sck_sync[2];
    assign sck_fall  = ~sck_sync[1] & sck_sync[2];
    assign start_det = sck_sync[1] & sck_sync[2] & ~sda_sync[1] & sda_sync[2];
    assign stop_det  = sck_sync[1] & sck_sync[2] & sda_sync[1] & ~sda_sync[2];

    assign byte_done = sck_fall && !acking && (bit_cnt == 4'd8) &&
                       ((state == st_ctrl) || (state == st_addr) || (state == st_data));
    assign ctrl_ok   = (shift[7:4] == dev_code);
    assign mem_we    = byte_done && (state == st_data);
    assign rd_load   = byte_done && (state == st_ctrl) && ctrl_ok && shift[0];
    assign rd_next   = sck_fall && (state == st_read) && (acking || (bit_cnt != 4'd8));

    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            sck_sync    <= 3'b111;
            sda_sync    <= 3'b111;
            state       <= st_idle;
            bit_cnt     <= 4'd0;
            acking      <= 1'b0;
            slv_sda_low <= 1'b0;
        end
        else
        begin
            sck_sync <= {sck_sync[1:0], sck};
            sda_sync <= {sda_sync[1:0], sda};
            if (start_det || stop_det)
            begin
                state       <= start_det ? st_ctrl : st_idle;
                bit_cnt     <= 4'd0;
                acking      <= 1'b0;
                slv_sda_low <= 1'b0;
            end
            else if (sck_rise && !acking && (state != st_idle))
            begin
                bit_cnt <= bit_cnt + 4'd1;
            end
            else if (sck_fall)
            begin
                if (acking)
                begin
                    // End of ACK, a read starts driving its MSB here
                    acking      <= 1'b0;
                    bit_cnt     <= 4'd0;
                    slv_sda_low <= (state == st_read) ? ~rd_byte[data_w-1] : 1'b0;
                end
                else if (byte_done)
                begin
                    bit_cnt <= 4'd0;
                    case (state)
                        st_ctrl:
                        begin
                            acking      <= ctrl_ok;
                            slv_sda_low <= ctrl_ok;
                            if (!ctrl_ok)
                                state <= st_idle;
                            else
                                state <= shift[0] ? st_read : st_addr;
                        end
                        st_addr:
                        begin
                            acking      <= 1'b1;
                            slv_sda_low <= 1'b1;
                            state       <= st_data;
                        end
                        default:
                        begin
                            acking      <= 1'b1;
                            slv_sda_low <= 1'b1;
                            state       <= st_idle;
                        end
                    endcase
                end
                else if (state == st_read)
                begin
                    // Release after the last bit, master NACK is not checked
                    if (bit_cnt == 4'd8)
                    begin
                        slv_sda_low <= 1'b0;
                        state       <= st_idle;
                    end
                    else
                    begin
                        slv_sda_low <= ~rd_byte[data_w-1];
                    end
                end
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (sck_rise)
            shift <= {shift[data_w-2:0], sda_sync[1]};
        if (byte_done && (state == st_ctrl))
            block <= shift[3:1];
        // Address byte survives a repeated start
        if (byte_done && (state == st_addr))
            addr_byte <= shift;
        if (mem_we)
            mem[{block, addr_byte}] <= shift;
        if (rd_load)
            rd_byte <= mem[{shift[3:1], addr_byte}];
        else if (rd_next)
            rd_byte <= {rd_byte[data_w-2:0], 1'b0};
    end

endmodule

// File: design/eeprom_sys.sv
`timescale 1ns/1ps

module eeprom_sys #(
    parameter int QUARTER_DIV = 4
) (
    input  logic                        scl,
    input  logic                        rst_n,
    input  logic                        cmd_valid,
    input  eeprom_cmd_pkg::eeprom_cmd_t cmd,
    output logic                        busy,
    output logic                        rsp_valid,
    output eeprom_cmd_pkg::eeprom_rsp_t rsp,
    output logic                        bus_sck,
    output logic                        bus_sda
);
    import eeprom_bus_pkg::*;

    logic    bit_go;
    bit_op_t bit_op;
    logic    bit_wr;
    logic    bit_done;
    logic    bit_rd;
    logic    eng_sda_low;
    logic    slv_sda_low;

    // Open-drain bus, high unless a side pulls low
    assign bus_sda = ~(eng_sda_low | slv_sda_low);

    eeprom_master master_i (
        .scl       (scl),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .bit_go    (bit_go),
        .bit_op    (bit_op),
        .bit_wr    (bit_wr),
        .bit_done  (bit_done),
        .bit_rd    (bit_rd)
    );

    eeprom_bit_engine #(
        .QUARTER_DIV (QUARTER_DIV)
    ) bit_engine_i (
        .scl         (scl),
        .rst_n       (rst_n),
        .bit_go      (bit_go),
        .bit_op      (bit_op),
        .bit_wr      (bit_wr),
        .sda_in      (bus_sda),
        .bit_done    (bit_done),
        .bit_rd      (bit_rd),
        .sck         (bus_sck),
        .eng_sda_low (eng_sda_low)
    );

    eeprom_slave slave_i (
        .scl         (scl),
        .rst_n       (rst_n),
        .sck         (bus_sck),
        .sda         (bus_sda),
        .slv_sda_low (slv_sda_low)
    );

endmodule

// File: sim/eeprom_sys_tb.sv
`timescale 1ns/1ps

module eeprom_sys_tb;
    import eeprom_bus_pkg::*;
    import eeprom_cmd_pkg::*;

    localparam int quarter_div = 4;
    localparam int rsp_timeout = 2000;
    localparam int idle_gap    = 4;
    localparam int mem_words   = 1 << addr_w;

    logic        scl;
    logic        rst_n;
    logic        cmd_valid;
    eeprom_cmd_t cmd;
    logic        busy;
    logic        rsp_valid;
    eeprom_rsp_t rsp;
    logic        bus_sck;
    logic        bus_sda;

    // Expected memory contents built from the trace writes
    logic [data_w-1:0] model [0:mem_words-1];
    logic              model_set [0:mem_words-1];

    int   test_errors;
    int   tests_passed;
    int   tests_failed;
    logic timed_out;

    eeprom_sys #(
        .QUARTER_DIV (quarter_div)
    ) eeprom_sys_i (
        .scl       (scl),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .bus_sck   (bus_sck),
        .bus_sda   (bus_sda)
    );

    initial
    begin
        scl = 1'b0;
        forever #5 scl = ~scl;
    end

    task automatic compare_rsp(input eeprom_rsp_t got, input eeprom_rsp_t exp);
        if (got.was_read !== exp.was_read)
        begin
            $display("MISMATCH rsp.was_read got 0x%0h exp 0x%0h", got.was_read, exp.was_read);
            test_errors++;
        end
        if (got.data !== exp.data)
        begin
            $display("MISMATCH rsp.data got 0x%02h exp 0x%02h", got.data, exp.data);
            test_errors++;
        end
    endtask

    // Idle bus is high on both lines
    task automatic compare_bus(input logic got_sck, input logic got_sda);
        if (got_sck !== 1'b1)
        begin
            $display("MISMATCH bus_sck got 0x%0h exp 0x1", got_sck);
            test_errors++;
        end
        if (got_sda !== 1'b1)
        begin
            $display("MISMATCH bus_sda got 0x%0h exp 0x1", got_sda);
            test_errors++;
        end
    endtask

    task automatic compare_ctrl(input logic got_busy, input logic got_rsp_valid,
                                input logic exp_busy, input logic exp_rsp_valid);
        if (got_busy !== exp_busy)
        begin
            $display("MISMATCH busy got 0x%0h exp 0x%0h", got_busy, exp_busy);
            test_errors++;
        end
        if (got_rsp_valid !== exp_rsp_valid)
        begin
            $display("MISMATCH rsp_valid got 0x%0h exp 0x%0h", got_rsp_valid, exp_rsp_valid);
            test_errors++;
        end
    endtask

    task automatic watch_idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge scl);
            compare_ctrl(busy, rsp_valid, 1'b0, 1'b0);
            compare_bus(bus_sck, bus_sda);
        end
    endtask

    task automatic wait_rsp(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && (cycles < rsp_timeout))
        begin
            @(negedge scl);
            cycles++;
            // Busy dropping without rsp_valid also ends the transaction
            if (rsp_valid || !busy)
                seen = 1'b1;
        end
        if (!seen)
        begin
            $display("timeout: rsp_valid did not arrive within %0d cycles", rsp_timeout);
            test_errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input logic [255:0] name);
        if (test_errors == 0)
        begin
            tests_passed++;
            $display("test %0s passed", name);
        end
        else
        begin
            tests_failed++;
            $display("test %0s failed with %0d errors", name, test_errors);
        end
    endtask

    task automatic run_record(input logic [255:0] name, input logic [7:0] op,
                              input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                              input logic busy_strobe);
        eeprom_cmd_t c;
        eeprom_cmd_t extra;
        eeprom_rsp_t exp;
        logic        seen;
        test_errors   = 0;
        c.is_read     = (op == "R");
        c.addr        = addr;
        c.data        = c.is_read ? '0 : data;
        // Would overwrite the address if it were not dropped
        extra.is_read = 1'b0;
        extra.addr    = addr;
        extra.data    = ~data;
        if ((op != "R") && (op != "W"))
        begin
            $display("unknown trace operation %0s in test %0s", op, name);
            test_errors++;
        end
        if (c.is_read)
        begin
            exp.was_read = 1'b1;
            exp.data     = data;
            if (!model_set[addr])
            begin
                $display("trace reads address 0x%03h before any write", addr);
                test_errors++;
            end
            else if (model[addr] !== data)
            begin
                $display("trace expects 0x%02h at 0x%03h but the model holds 0x%02h",
                         data, addr, model[addr]);
                test_errors++;
            end
        end
        else
        begin
            exp             = '0;
            model[addr]     = data;
            model_set[addr] = 1'b1;
        end

        @(negedge scl);
        cmd_valid = 1'b1;
        cmd       = c;
        @(negedge scl);
        cmd_valid = 1'b0;
        if (busy_strobe)
        begin
            compare_ctrl(busy, rsp_valid, 1'b1, 1'b0);
            cmd_valid = 1'b1;
            cmd       = extra;
            @(negedge scl);
            cmd_valid = 1'b0;
        end

        wait_rsp(seen);
        if (seen)
        begin
            compare_rsp(rsp, exp);
            compare_ctrl(busy, rsp_valid, 1'b0, 1'b1);
            compare_bus(bus_sck, bus_sda);
            // Also catches a second response from a dropped strobe
            watch_idle(idle_gap);
        end
        report_test(name);
    endtask

    initial
    begin
        int                fd;
        int                status;
        int                records;
        logic [255:0]      tok;
        logic [1023:0]     line;
        logic [7:0]        op;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [3:0]        flag;

        rst_n        = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = '0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        records      = 0;
        for (int a = 0; a < mem_words; a++)
            model_set[a] = 1'b0;

        repeat (2) @(negedge scl);
        rst_n = 1'b1;

        test_errors = 0;
        watch_idle(idle_gap);
        report_test("reset_idle");

        fd = $fopen("sim/eeprom_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file sim/eeprom_trace.txt");
            tests_failed++;
        end
        else
        begin
            while (!timed_out && ($fscanf(fd, "%s", tok) == 1))
            begin
                if (tok == "#")
                begin
                    status = $fgets(line, fd);
                end
                else
                begin
                    status = $fscanf(fd, " %c %h %h %h", op, addr, data, flag);
                    if (status != 4)
                    begin
                        $display("malformed trace record after %0s", tok);
                        tests_failed++;
                        break;
                    end
                    records++;
                    run_record(tok, op, addr, data, flag != 4'd0);
                end
            end
            $fclose(fd);
            if (records == 0)
            begin
                $display("the trace file held no records");
                tests_failed++;
            end
        end

        $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: sim/eeprom_trace.txt
# name op addr data busy with addr and data in hex
# op W writes data and op R expects data back and busy 1 adds a write that must be dropped
# Write then read back
wr_basic W 123 5a 0
rd_basic R 123 5a 0
# Block bits in the control byte
wr_blk0 W 0a5 11 0
wr_blk3 W 3a5 22 0
wr_blk7 W 7a5 33 0
rd_blk0 R 0a5 11 0
rd_blk3 R 3a5 22 0
rd_blk7 R 7a5 33 0
# Overwrite with the neighbour unchanged
wr_nbr W 200 c3 0
wr_first W 201 0f 0
wr_again W 201 f0 0
rd_again R 201 f0 0
rd_nbr R 200 c3 0
# Strobe while busy is dropped
wr_busy W 345 a7 1
rd_busy R 345 a7 1
rd_check R 345 a7 0
# Lowest and highest address
wr_low W 000 01 0
wr_high W 7ff fe 0
rd_low R 000 01 0
rd_high R 7ff fe 0

// File: list.f
design/eeprom_bus_pkg.sv
design/eeprom_cmd_pkg.sv
design/eeprom_bit_engine.sv
design/eeprom_master.sv
design/eeprom_slave.sv
design/eeprom_sys.sv
sim/eeprom_sys_tb.sv

// File: Bender.yml
package:
  name: eeprom_sys

sources:
  - files:
      - design/eeprom_bus_pkg.sv
      - design/eeprom_cmd_pkg.sv
      - design/eeprom_bit_engine.sv
      - design/eeprom_master.sv
      - design/eeprom_slave.sv
      - design/eeprom_sys.sv
  - target: simulation
    files:
      - sim/eeprom_sys_tb.sv
